// File: source/pagePkg.sv
package pagePkg;

  localparam int vmaWidth = 14;
  localparam int physWidth = 13;
  localparam int ptIndexWidth = 8;
  localparam int dirIndexWidth = 7;
  localparam int dirTagWidth = 6;
  localparam int halfWidth = 18;
  localparam int failCodeWidth = 3;

  localparam logic [failCodeWidth-1:0] failNone = 3'd0;
  localparam logic [failCodeWidth-1:0] failParity = 3'd1;
  localparam logic [failCodeWidth-1:0] failNoAccess = 3'd2;
  localparam logic [failCodeWidth-1:0] failWrite = 3'd3;
  localparam logic [failCodeWidth-1:0] failPrivate = 3'd4;

  // One page table half, MSB is bit 0 of the half
  typedef struct packed {
    logic access;
    logic public;
    logic writable;
    logic software;
    logic cache;
    logic [physWidth-1:0] page;
  } ptFields;

  // Raw view is the bus word, also what parity covers
  typedef union packed {
    logic [halfWidth-1:0] raw;
    ptFields f;
  } ptHalf;

endpackage

// File: source/ptAddress.sv
module ptAddress (
  input  logic clk,
  input  logic rstN,
  input  logic refStrobe,
  input  logic ptWrite,
  input  logic dirClear,
  input  logic [13:13+pagePkg::vmaWidth-1] vma,
  input  logic user,
  input  logic writeRef,
  input  logic paged,
  input  logic testPrivate,
  input  logic ptWriteBoth,
  input  logic [0:2*pagePkg::halfWidth-1] ptData,
  input  logic [0:1] ptPar,
  output logic opRef,
  output logic opWrite,
  output logic opClear,
  output logic [18:18+pagePkg::ptIndexWidth-1] ptIndex,
  output logic [0:pagePkg::dirTagWidth-1] dirTag,
  output logic wrLeft,
  output logic wrRight,
  output logic [0:2*pagePkg::halfWidth-1] wrData,
  output logic [0:1] wrPar,
  output logic reqUser,
  output logic reqWrite,
  output logic reqPaged,
  output logic reqPrivate,
  output logic [14:14+pagePkg::physWidth-1] reqLow
);

  logic [18:18+pagePkg::ptIndexWidth-1] hashAdr;

  // Exec and user spaces land in different table words
  always_comb begin
    hashAdr = vma[18:25];
    hashAdr[19] = vma[19] ^ ~user;
    hashAdr[20] = vma[17] ^ vma[20];
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      opRef <= 1'b0;
      opWrite <= 1'b0;
      opClear <= 1'b0;
    end else begin
      opRef <= refStrobe;
      opWrite <= ptWrite;
      opClear <= dirClear;
    end
  end

  always_ff @(posedge clk) begin
    ptIndex <= hashAdr;
    dirTag <= {user, vma[13:17]};
    // Bit 26 picks the odd page half
    wrLeft <= ptWriteBoth | ~vma[26];
    wrRight <= ptWriteBoth | vma[26];
    wrData <= ptData;
    wrPar <= ptPar;
    reqUser <= user;
    reqWrite <= writeRef;
    reqPaged <= paged;
    reqPrivate <= testPrivate;
    reqLow <= vma[14:26];
  end

  strobeOneHot: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0({refStrobe, ptWrite, dirClear}))
    else $error("more than one pager strobe in a cycle");

endmodule

// File: source/pageTable.sv
module pageTable (
  input  logic clk,
  input  logic rstN,
  input  logic opRef,
  input  logic opWrite,
  input  logic opClear,
  input  logic [18:18+pagePkg::ptIndexWidth-1] ptIndex,
  input  logic [0:pagePkg::dirTagWidth-1] dirTag,
  input  logic wrLeft,
  input  logic wrRight,
  input  logic [0:2*pagePkg::halfWidth-1] wrData,
  input  logic [0:1] wrPar,
  input  logic reqUser,
  input  logic reqWrite,
  input  logic reqPaged,
  input  logic reqPrivate,
  input  logic [14:14+pagePkg::physWidth-1] reqLow,
  output logic resRef,
  output logic hit,
  output pagePkg::ptHalf entryHalf,
  output logic halfPar,
  output logic resUser,
  output logic resWrite,
  output logic resPaged,
  output logic resPrivate,
  output logic [14:14+pagePkg::physWidth-1] resLow
);

  logic [0:2*pagePkg::halfWidth-1] ptMem [2**pagePkg::ptIndexWidth];
  logic [0:1] parMem [2**pagePkg::ptIndexWidth];
  logic [0:pagePkg::dirTagWidth-1] tagMem [2**pagePkg::dirIndexWidth];
  // Valid per value of table address bit 25
  logic [0:2**pagePkg::dirIndexWidth-1] validEven;
  logic [0:2**pagePkg::dirIndexWidth-1] validOdd;

  logic [18:18+pagePkg::dirIndexWidth-1] dirIndex;
  logic [0:2*pagePkg::halfWidth-1] rdWord;
  logic [0:1] rdPar;
  logic rdValid;
  logic tagMatch;

  assign dirIndex = ptIndex[18:24];

  always_comb begin
    rdWord = ptMem[ptIndex];
    rdPar = parMem[ptIndex];
    rdValid = ptIndex[25] ? validOdd[dirIndex] : validEven[dirIndex];
    tagMatch = rdValid && (tagMem[dirIndex] == dirTag);
  end

  always_ff @(posedge clk) begin
    if (opWrite) begin
      if (wrLeft) begin
        ptMem[ptIndex][0:pagePkg::halfWidth-1] <= wrData[0:pagePkg::halfWidth-1];
        parMem[ptIndex][0] <= wrPar[0];
      end
      if (wrRight) begin
        ptMem[ptIndex][pagePkg::halfWidth:2*pagePkg::halfWidth-1] <=
          wrData[pagePkg::halfWidth:2*pagePkg::halfWidth-1];
        parMem[ptIndex][1] <= wrPar[1];
      end
      // Refill completes here
      tagMem[dirIndex] <= dirTag;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validEven <= '0;
      validOdd <= '0;
    end else if (opClear) begin
      validEven <= '0;
      validOdd <= '0;
    end else if (opWrite) begin
      if (ptIndex[25]) begin
        validOdd[dirIndex] <= 1'b1;
      end else begin
        validEven[dirIndex] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resRef <= 1'b0;
    end else begin
      resRef <= opRef;
    end
  end

  // Read register, half picked by vma bit 26
  always_ff @(posedge clk) begin
    if (opRef) begin
      hit <= tagMatch;
      entryHalf.raw <= reqLow[26] ? rdWord[pagePkg::halfWidth:2*pagePkg::halfWidth-1]
                                  : rdWord[0:pagePkg::halfWidth-1];
      halfPar <= reqLow[26] ? rdPar[1] : rdPar[0];
      resUser <= reqUser;
      resWrite <= reqWrite;
      resPaged <= reqPaged;
      resPrivate <= reqPrivate;
      resLow <= reqLow;
    end
  end

  writeHasHalf: assert property (@(posedge clk) disable iff (!rstN)
    opWrite |-> (wrLeft || wrRight))
    else $error("page table write with no half enabled");

endmodule

// File: source/pageCheck.sv
module pageCheck (
  input  logic clk,
  input  logic rstN,
  input  logic resRef,
  input  logic hit,
  input  pagePkg::ptHalf entryHalf,
  input  logic halfPar,
  input  logic resUser,
  input  logic resWrite,
  input  logic resPaged,
  input  logic resPrivate,
  input  logic [14:14+pagePkg::physWidth-1] resLow,
  output logic resStrobe,
  output logic pageOk,
  output logic pageRefill,
  output logic pageFail,
  output logic [pagePkg::failCodeWidth-1:0] failCode,
  output logic [14:14+pagePkg::physWidth-1] physPage
);

  logic unpaged;
  logic parityBad;
  logic nextOk;
  logic nextRefill;
  logic nextFail;
  logic [pagePkg::failCodeWidth-1:0] nextCode;
  logic [14:14+pagePkg::physWidth-1] nextPhys;

  always_comb begin
    // User references are always translated
    unpaged = !resPaged && !resUser;
    // Good halves carry odd parity
    parityBad = ~^{entryHalf.raw, halfPar};
    nextOk = 1'b0;
    nextRefill = 1'b0;
    nextFail = 1'b0;
    nextCode = pagePkg::failNone;
    nextPhys = resLow;
    if (resRef) begin
      if (unpaged) begin
        nextOk = 1'b1;
      end else if (!hit) begin
        nextRefill = 1'b1;
      end else begin
        nextFail = 1'b1;
        if (parityBad) begin
          nextCode = pagePkg::failParity;
        end else if (!entryHalf.f.access) begin
          nextCode = pagePkg::failNoAccess;
        end else if (resWrite && !entryHalf.f.writable) begin
          nextCode = pagePkg::failWrite;
        end else if (resPrivate && !entryHalf.f.public) begin
          nextCode = pagePkg::failPrivate;
        end else begin
          nextFail = 1'b0;
          nextOk = 1'b1;
          nextPhys = entryHalf.f.page;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resStrobe <= 1'b0;
      pageOk <= 1'b0;
      pageRefill <= 1'b0;
      pageFail <= 1'b0;
      failCode <= pagePkg::failNone;
    end else begin
      resStrobe <= resRef;
      pageOk <= nextOk;
      pageRefill <= nextRefill;
      pageFail <= nextFail;
      failCode <= nextCode;
    end
  end

  always_ff @(posedge clk) begin
    physPage <= nextPhys;
  end

  outcomeExclusive: assert property (@(posedge clk) disable iff (!rstN)
    $onehot0({pageOk, pageRefill, pageFail}))
    else $error("more than one pager outcome");

  outcomeWithStrobe: assert property (@(posedge clk) disable iff (!rstN)
    (pageOk || pageRefill || pageFail) |-> resStrobe)
    else $error("pager outcome without result strobe");

endmodule

// File: source/pager.sv
module pager (
  input  logic clk,
  input  logic rstN,
  input  logic refStrobe,
  input  logic ptWrite,
  input  logic dirClear,
  input  logic [13:13+pagePkg::vmaWidth-1] vma,
  input  logic user,
  input  logic writeRef,
  input  logic paged,
  input  logic testPrivate,
  input  logic ptWriteBoth,
  input  logic [0:2*pagePkg::halfWidth-1] ptData,
  input  logic [0:1] ptPar,
  output logic resStrobe,
  output logic pageOk,
  output logic pageRefill,
  output logic pageFail,
  output logic [pagePkg::failCodeWidth-1:0] failCode,
  output logic [14:14+pagePkg::physWidth-1] physPage
);

  // Address stage to table
  logic opRef;
  logic opWrite;
  logic opClear;
  logic [18:18+pagePkg::ptIndexWidth-1] ptIndex;
  logic [0:pagePkg::dirTagWidth-1] dirTag;
  logic wrLeft;
  logic wrRight;
  logic [0:2*pagePkg::halfWidth-1] wrData;
  logic [0:1] wrPar;
  logic reqUser;
  logic reqWrite;
  logic reqPaged;
  logic reqPrivate;
  logic [14:14+pagePkg::physWidth-1] reqLow;

  // Table to check stage
  logic resRef;
  logic hit;
  pagePkg::ptHalf entryHalf;
  logic halfPar;
  logic resUser;
  logic resWrite;
  logic resPaged;
  logic resPrivate;
  logic [14:14+pagePkg::physWidth-1] resLow;

  ptAddress uAddress (.*);

  pageTable uTable (.*);

  pageCheck uCheck (.*);

endmodule

// File: tests/pagerModel.svh
typedef struct {
  int due;
  logic ok;
  logic refill;
  logic fail;
  logic [pagePkg::failCodeWidth-1:0] code;
  logic [14:26] phys;
} expResult;

logic [0:35] mdlWord [256];
logic [0:1] mdlPar [256];
logic [0:5] mdlTag [128];
// Valid per full table address, the low bit picks one of two per tag
bit mdlValid [256];

// Exec flips bit 19, virtual bit 17 folds into bit 20
function automatic logic [18:25] hashIndex(logic [13:26] v, logic u);
  logic [18:25] a;
  a = v[18:25];
  a[19] = v[19] ^ !u;
  a[20] = v[17] ^ v[20];
  return a;
endfunction

function automatic void modelWrite(logic [13:26] v, logic u, logic both,
                                   logic [0:35] d, logic [0:1] par);
  logic [18:25] a;
  a = hashIndex(v, u);
  for (int s = 0; s < 2; s++) begin
    if (both || v[26] == s) begin
      mdlWord[a][s*18 +: 18] = d[s*18 +: 18];
      mdlPar[a][s] = par[s];
    end
  end
  mdlTag[a[18:24]] = {u, v[13:17]};
  mdlValid[a] = 1'b1;
endfunction

function automatic expResult modelLookup(logic [13:26] v, logic u, logic w, logic p,
                                         logic priv);
  expResult r;
  logic [18:25] a;
  pagePkg::ptHalf h;
  a = hashIndex(v, u);
  h.raw = mdlWord[a][v[26]*18 +: 18];
  r.due = 0;
  r.ok = 1'b0;
  r.refill = 1'b0;
  r.fail = 1'b0;
  r.code = pagePkg::failNone;
  r.phys = v[14:26];
  // User references are never unpaged
  if (!p && !u) begin
    r.ok = 1'b1;
  end else if (!mdlValid[a] || mdlTag[a[18:24]] != {u, v[13:17]}) begin
    r.refill = 1'b1;
  end else begin
    if (^{h.raw, mdlPar[a][v[26]]} == 1'b0) begin
      r.code = pagePkg::failParity;
    end else if (!h.f.access) begin
      r.code = pagePkg::failNoAccess;
    end else if (w && !h.f.writable) begin
      r.code = pagePkg::failWrite;
    end else if (priv && !h.f.public) begin
      r.code = pagePkg::failPrivate;
    end
    r.fail = r.code != pagePkg::failNone;
    r.ok = !r.fail;
    if (r.ok) begin
      r.phys = h.f.page;
    end
  end
  return r;
endfunction

// File: tests/pagerTb.sv
module pagerTb;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk = 1'b0;
  logic rstN, refStrobe, ptWrite, dirClear, user, writeRef, paged, testPrivate, ptWriteBoth;
  logic [13:26] vma;
  logic [0:35] ptData;
  logic [0:1] ptPar;
  logic resStrobe, pageOk, pageRefill, pageFail;
  logic [pagePkg::failCodeWidth-1:0] failCode;
  logic [14:26] physPage;
  logic [31:0] lfsr = 32'h8daf8686;
  // Small pool so that lookups hit again
  logic [13:26] vmaPool [4] = '{14'h0123, 14'h2a54, 14'h1f0e, 14'h3c91};
  int cycleCount = 0;
  int checkCount = 0;
  int errCount = 0;
  int testErrs = 0;

  `include "pagerModel.svh"

  expResult expQ [$];

  pager dut (.*);

  always #2 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] randBits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Both halves accessible with good parity, then the two parity bits
  function automatic logic [0:37] goodEntry();
    pagePkg::ptHalf h0;
    pagePkg::ptHalf h1;
    h0.raw = randBits(18);
    h1.raw = randBits(18);
    h0.f.access = 1'b1;
    h1.f.access = 1'b1;
    return {h0.raw, h1.raw, ~^h0.raw, ~^h1.raw};
  endfunction

  task automatic checkFlag(string name, logic got, logic exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkFailCode(logic [pagePkg::failCodeWidth-1:0] got,
                               logic [pagePkg::failCodeWidth-1:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("Error at %0t: failCode got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic checkPhys(logic [14:26] got, logic [14:26] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("Error at %0t: physPage got %h expected %h", $time, got, exp);
    end
  endtask

  // op 0 idle, 1 lookup, 2 table write, 3 directory clear
  // attr is writeRef, paged, testPrivate, ptWriteBoth
  task automatic issue(int op, logic [13:26] v, logic u, logic [0:3] attr,
                       logic [0:35] d, logic [0:1] par);
    expResult e;
    @(posedge clk);
    cycleCount++;
    #1;
    if (expQ.size() != 0 && expQ[0].due == cycleCount) begin
      e = expQ.pop_front();
      checkFlag("resStrobe", resStrobe, 1'b1);
      checkFlag("pageOk", pageOk, e.ok);
      checkFlag("pageRefill", pageRefill, e.refill);
      checkFlag("pageFail", pageFail, e.fail);
      checkFailCode(failCode, e.code);
      if (e.ok) begin
        checkPhys(physPage, e.phys);
      end
    end else begin
      checkFlag("resStrobe", resStrobe, 1'b0);
    end
    {vma, user, ptData, ptPar} = {v, u, d, par};
    {writeRef, paged, testPrivate, ptWriteBoth} = attr;
    {refStrobe, ptWrite, dirClear} = {op == 1, op == 2, op == 3};
    if (op == 1) begin
      e = modelLookup(v, u, attr[0], attr[1], attr[2]);
      e.due = cycleCount + 3;
      expQ.push_back(e);
    end else if (op == 2) begin
      modelWrite(v, u, attr[3], d, par);
    end else if (op == 3) begin
      mdlValid = '{default: 0};
    end
  endtask

  // Random op on a pool page, a directory clear now and then if allowed
  task automatic randomOp(bit allowClear);
    logic [13:26] v;
    pagePkg::ptHalf h [2];
    logic [0:1] par;
    logic [0:3] attr;
    logic u;
    int op;
    v = vmaPool[randBits(2)];
    v[26] = randBits(1);
    u = randBits(1);
    attr = randBits(4);
    // Mostly paged
    attr[1] = attr[1] | randBits(1);
    for (int s = 0; s < 2; s++) begin
      h[s].raw = randBits(18);
      h[s].f.access = randBits(2) != 0;
      par[s] = ~^h[s].raw ^ (randBits(3) == 0);
    end
    op = randBits(3);
    if (op == 0 && allowClear) begin
      op = 3;
    end else begin
      op = (op < 3) ? 2 : 1;
    end
    issue(op, v, u, attr, {h[0].raw, h[1].raw}, par);
  endtask

  task automatic endTest(string name);
    int waited;
    waited = 0;
    while (expQ.size() != 0 && waited < 12) begin
      issue(0, vma, user, 4'b0000, ptData, ptPar);
      waited++;
    end
    if (expQ.size() != 0) begin
      errCount++;
      $display("%s: %0d lookup results never arrived", name, expQ.size());
      expQ.delete();
    end
    $display("%s: %0d errors", name, errCount - testErrs);
    testErrs = errCount;
  endtask

  initial begin
    logic [13:26] v;
    logic [0:37] ent;
    logic [0:37] ent2;
    {rstN, refStrobe, ptWrite, dirClear, user, writeRef, paged, testPrivate, ptWriteBoth} = '0;
    vma = '0;
    ptData = '0;
    ptPar = '0;
    repeat (3) @(posedge clk);
    #1;
    rstN = 1'b1;

    v = vmaPool[2];
    issue(1, v, 1'b0, 4'b0100, ptData, ptPar);
    issue(1, v, 1'b0, 4'b0000, ptData, ptPar);
    issue(1, v, 1'b1, 4'b0000, ptData, ptPar);
    endTest("reset lookups");

    v = vmaPool[0];
    v[26] = 1'b0;
    ent = goodEntry();
    issue(2, v, 1'b0, 4'b0001, ent[0:35], ent[36:37]);
    issue(1, v, 1'b0, 4'b0100, ptData, ptPar);
    v[26] = 1'b1;
    issue(1, v, 1'b0, 4'b0100, ptData, ptPar);
    endTest("two-half write");

    // Odd half alone, then the even half with flipped parity
    ent2 = goodEntry();
    issue(2, v, 1'b0, 4'b0000, ent2[0:35], ent2[36:37]);
    issue(1, v, 1'b0, 4'b0100, ptData, ptPar);
    v[26] = 1'b0;
    issue(1, v, 1'b0, 4'b0100, ptData, ptPar);
    issue(2, v, 1'b0, 4'b0000, ent2[0:35], ~ent2[36:37]);
    issue(1, v, 1'b0, 4'b0100, ptData, ptPar);
    endTest("half writes");

    // Every pool page gets a full entry in both spaces first
    for (int i = 0; i < 8; i++) begin
      ent = goodEntry();
      issue(2, vmaPool[i / 2], i % 2, 4'b0001, ent[0:35], ent[36:37]);
    end
    repeat (300) randomOp(1'b0);
    endTest("random checks");

    issue(3, vma, user, 4'b0000, ptData, ptPar);
    v = vmaPool[3];
    ent = goodEntry();
    issue(2, v, 1'b0, 4'b0001, ent[0:35], ent[36:37]);
    issue(1, v, 1'b0, 4'b0100, ptData, ptPar);
    issue(1, v, 1'b1, 4'b0100, ptData, ptPar);
    issue(3, vma, user, 4'b0000, ptData, ptPar);
    for (int i = 0; i < 8; i++) begin
      issue(1, vmaPool[i / 2], i % 2, 4'b0100, ptData, ptPar);
    end
    endTest("exec user clear");

    repeat (200) randomOp(1'b1);
    endTest("back to back");

    $display("%0d checks, %0d errors", checkCount, errCount);
    if (errCount == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: pager.f
+incdir+tests
source/pagePkg.sv
source/ptAddress.sv
source/pageTable.sv
source/pageCheck.sv
source/pager.sv
tests/pagerTb.sv

// File: Bender.yml
package:
  name: pager

sources:
  - source/pagePkg.sv
  - source/ptAddress.sv
  - source/pageTable.sv
  - source/pageCheck.sv
  - source/pager.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/pagerTb.sv
